// ==== hw/u1e_pkg.sv ====
package u1e_pkg;

   ////////////////////
   // host bus

   localparam int DW       = 16;    // data width
   localparam int AW       = 11;    // byte address width
   localparam int SW       = 2;     // byte selects
   localparam int DECODE_W = 4;     // top address bits pick the slave

   // slave numbers on the top nibble
   localparam logic [DECODE_W-1:0] SLV_MISC = 4'd0;
   localparam logic [DECODE_W-1:0] SLV_RDBK = 4'd7;
   localparam logic [DECODE_W-1:0] SLV_SET  = 4'd8;   // 8 and 9, double wide

   ////////////////////
   // settings bus

   localparam int SET_AW = 8;
   localparam int SET_DW = 32;

   localparam int SR_TIME64     = 40;   // +0 high word, +1 low word
   localparam int SR_REG_TEST32 = 52;

   ////////////////////
   // slave 0 byte offsets

   localparam logic [6:0] REG_LEDS      = 7'd0;
   localparam logic [6:0] REG_CGEN_CTRL = 7'd4;
   localparam logic [6:0] REG_CGEN_ST   = 7'd6;   // read only
   localparam logic [6:0] REG_TEST      = 7'd8;
   localparam logic [6:0] REG_COMPAT    = 7'd16;  // read only

   localparam logic [7:0]  COMPAT_NUM      = 8'd3;
   localparam logic [15:0] READ_DEFAULT    = 16'hBEEF;
   localparam logic [1:0]  CGEN_CTRL_RESET = 2'b11;  // sync_b high, ref_sel high

endpackage

// ==== hw/wb_if.sv ====
interface wb_if import u1e_pkg::*; ();

   logic [AW-1:0] adr;
   logic [DW-1:0] dat_mosi;
   logic [DW-1:0] dat_miso;
   logic [SW-1:0] sel;
   logic          we;
   logic          cyc;
   logic          stb;
   logic          ack;

   modport master (
      output adr, dat_mosi, sel, we, cyc, stb,
      input  dat_miso, ack
   );

   modport slave (
      input  adr, dat_mosi, sel, we, cyc, stb,
      output dat_miso, ack
   );

endinterface

// ==== hw/setting_reg.sv ====
module setting_reg import u1e_pkg::*; #(
   parameter int my_addr = 0,
   parameter int width   = 32
) (
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  logic              set_stb_i,
   input  logic [SET_AW-1:0] set_addr_i,
   input  logic [SET_DW-1:0] set_data_i,
   output logic [width-1:0]  out_o,
   output logic              changed_o
);

   logic hit;

   assign hit = set_stb_i & (set_addr_i == SET_AW'(my_addr));

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         out_o     <= '0;
         changed_o <= 1'b0;
      end
      else
      begin
         changed_o <= hit;      // one cycle pulse with the new value
         if (hit)
            out_o <= set_data_i[width-1:0];
      end
   end

endmodule

// ==== hw/time_64bit.sv ====
module time_64bit import u1e_pkg::*; #(
   parameter int base = 0
) (
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  logic              set_stb_i,
   input  logic [SET_AW-1:0] set_addr_i,
   input  logic [SET_DW-1:0] set_data_i,
   input  logic              pps_i,
   output logic [63:0]       vita_time_o,
   output logic [63:0]       vita_time_pps_o
);

   logic [31:0] time_hi, time_lo;
   logic        load;
   logic [63:0] count_q;     // free running tick count
   logic [2:0]  pps_sync;    // two sync flops plus edge history
   logic        pps_edge;

   // high word is staged, the low word write starts the load
   setting_reg #(.my_addr(base), .width(32)) sr_time_hi (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .out_o(time_hi), .changed_o()
   );

   setting_reg #(.my_addr(base+1), .width(32)) sr_time_lo (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .out_o(time_lo), .changed_o(load)
   );

   // loaded value shows in the cycle of the change pulse
   assign vita_time_o = load ? {time_hi, time_lo} : count_q;

   assign pps_edge = pps_sync[1] & ~pps_sync[2];

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         count_q         <= '0;
         vita_time_pps_o <= '0;
         pps_sync        <= '0;
      end
      else
      begin
         pps_sync <= {pps_sync[1:0], pps_i};
         count_q  <= vita_time_o + 64'd1;
         if (pps_edge)
            vita_time_pps_o <= vita_time_o;   // snapshot on rising pps
      end
   end

endmodule

// ==== hw/settings_bus_16le.sv ====
module settings_bus_16le import u1e_pkg::*; #(
   parameter int rwidth = 6
) (
   input  logic              wb_clk,
   input  logic              wb_rst,
   wb_if.slave               bus,
   output logic              set_stb_o,
   output logic [SET_AW-1:0] set_addr_o,
   output logic [SET_DW-1:0] set_data_o
);

   logic [DW-1:0] low_q;    // low half waits for the high half
   logic          wr;

   assign wr           = bus.cyc & bus.stb & bus.we;
   assign bus.ack      = bus.cyc & bus.stb;
   assign bus.dat_miso = '0;     // write only

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= wr & bus.adr[1];
      if (wr & ~bus.adr[1])
         low_q <= bus.dat_mosi;
      if (wr & bus.adr[1])
      begin
         set_addr_o <= {{(SET_AW-rwidth){1'b0}}, bus.adr[rwidth+1:2]};
         set_data_o <= {bus.dat_mosi, low_q};
      end
   end

endmodule

// ==== hw/misc_regs.sv ====
module misc_regs import u1e_pkg::*; (
   input  logic       wb_clk,
   input  logic       wb_rst,
   wb_if.slave        bus,
   input  logic       cgen_st_status_i,
   input  logic       cgen_st_ld_i,
   input  logic       cgen_st_refmon_i,
   output logic [1:0] leds_o,
   output logic       cgen_sync_b_o,
   output logic       cgen_ref_sel_o
);

   logic [DW-1:0] reg_leds;
   logic [1:0]    reg_cgen_ctrl;
   logic [DW-1:0] reg_test;
   logic          wr;

   // byte lane merge
   function automatic logic [DW-1:0] lane_merge(input logic [DW-1:0] old_v,
                                                input logic [DW-1:0] new_v,
                                                input logic [SW-1:0] be);
      logic [DW-1:0] res;
      res = old_v;
      if (be[0])
         res[7:0] = new_v[7:0];
      if (be[1])
         res[15:8] = new_v[15:8];
      return res;
   endfunction

   assign wr      = bus.cyc & bus.stb & bus.we;
   assign bus.ack = bus.cyc & bus.stb;    // no wait states

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= CGEN_CTRL_RESET;
         reg_test      <= '0;
      end
      else if (wr)
      begin
         case (bus.adr[6:0])
            REG_LEDS      : reg_leds <= lane_merge(reg_leds, bus.dat_mosi, bus.sel);
            REG_CGEN_CTRL :
               if (bus.sel[0])
                  reg_cgen_ctrl <= bus.dat_mosi[1:0];
            REG_TEST      : reg_test <= lane_merge(reg_test, bus.dat_mosi, bus.sel);
            default       : ;             // read only or unused
         endcase
      end
   end

   assign leds_o = reg_leds[1:0];
   assign {cgen_sync_b_o, cgen_ref_sel_o} = reg_cgen_ctrl;

   always_comb
   begin
      case (bus.adr[6:0])
         REG_LEDS      : bus.dat_miso = reg_leds;
         REG_CGEN_CTRL : bus.dat_miso = {14'd0, reg_cgen_ctrl};
         REG_CGEN_ST   : bus.dat_miso = {13'd0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         REG_TEST      : bus.dat_miso = reg_test;
         REG_COMPAT    : bus.dat_miso = {8'd0, COMPAT_NUM};
         default       : bus.dat_miso = READ_DEFAULT;
      endcase
   end

endmodule

// ==== hw/wb_readback_mux_16le.sv ====
module wb_readback_mux_16le import u1e_pkg::*; (
   input  logic        wb_clk,
   input  logic        wb_rst,
   wb_if.slave         bus,
   input  logic [63:0] vita_time_i,
   input  logic [63:0] vita_time_pps_i,
   input  logic [31:0] test32_i
);

   logic [31:0]   word;
   logic          ack_q;
   logic [DW-1:0] dat_q;

   always_comb
   begin
      case (bus.adr[5:2])
         4'd0    : word = vita_time_i[63:32];
         4'd1    : word = vita_time_i[31:0];
         4'd2    : word = vita_time_pps_i[63:32];
         4'd3    : word = vita_time_pps_i[31:0];
         4'd4    : word = test32_i;
         default : word = '0;
      endcase
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         ack_q <= 1'b0;
      else
         ack_q <= bus.cyc & bus.stb & ~ack_q;   // single cycle ack
      dat_q <= bus.adr[1] ? word[31:16] : word[15:0];
   end

   assign bus.ack      = ack_q;
   assign bus.dat_miso = dat_q;

endmodule

// ==== hw/wb_intercon.sv ====
module wb_intercon import u1e_pkg::*; (
   input  logic          wb_clk,
   input  logic          wb_rst,
   input  logic [AW-1:0] m_adr_i,
   input  logic [DW-1:0] m_dat_i,
   input  logic [SW-1:0] m_sel_i,
   input  logic          m_we_i,
   input  logic          m_cyc_i,
   input  logic          m_stb_i,
   output logic [DW-1:0] m_dat_o,
   output logic          m_ack_o,
   wb_if.master          misc,
   wb_if.master          rdbk,
   wb_if.master          settings
);

   localparam logic [DECODE_W-1:0] SET_MASK = 4'hE;

   logic [DECODE_W-1:0] nibble;
   logic [DECODE_W-1:0] slave_q;     // decode held while a slave is waiting
   logic                busy_q;
   logic                hit_misc, hit_rdbk, hit_set;

   assign nibble = busy_q ? slave_q : m_adr_i[AW-1 -: DECODE_W];

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         busy_q <= 1'b0;
      else
         busy_q <= m_cyc_i & m_stb_i & ~m_ack_o;  // slave has not answered yet
      slave_q <= nibble;
   end

   assign hit_misc = (nibble == SLV_MISC);
   assign hit_rdbk = (nibble == SLV_RDBK);
   assign hit_set  = ((nibble & SET_MASK) == (SLV_SET & SET_MASK));

   // broadcast to all slaves
   assign misc.adr          = m_adr_i;
   assign misc.dat_mosi     = m_dat_i;
   assign misc.sel          = m_sel_i;
   assign misc.we           = m_we_i;
   assign rdbk.adr          = m_adr_i;
   assign rdbk.dat_mosi     = m_dat_i;
   assign rdbk.sel          = m_sel_i;
   assign rdbk.we           = m_we_i;
   assign settings.adr      = m_adr_i;
   assign settings.dat_mosi = m_dat_i;
   assign settings.sel      = m_sel_i;
   assign settings.we       = m_we_i;

   assign misc.cyc     = m_cyc_i & hit_misc;
   assign misc.stb     = m_stb_i & hit_misc;
   assign rdbk.cyc     = m_cyc_i & hit_rdbk;
   assign rdbk.stb     = m_stb_i & hit_rdbk;
   assign settings.cyc = m_cyc_i & hit_set;
   assign settings.stb = m_stb_i & hit_set;

   always_comb
   begin
      if (hit_misc)
      begin
         m_dat_o = misc.dat_miso;
         m_ack_o = misc.ack;
      end
      else if (hit_rdbk)
      begin
         m_dat_o = rdbk.dat_miso;
         m_ack_o = rdbk.ack;
      end
      else if (hit_set)
      begin
         m_dat_o = settings.dat_miso;
         m_ack_o = settings.ack;
      end
      else
      begin
         m_dat_o = '0;                    // nothing mapped here
         m_ack_o = m_cyc_i & m_stb_i;
      end
   end

endmodule

// ==== hw/u1e_core.sv ====
module u1e_core import u1e_pkg::*; (
   input  logic          wb_clk,
   input  logic          wb_rst,
   // host bus
   input  logic [AW-1:0] m_adr_i,
   input  logic [DW-1:0] m_dat_i,
   input  logic [SW-1:0] m_sel_i,
   input  logic          m_we_i,
   input  logic          m_cyc_i,
   input  logic          m_stb_i,
   output logic [DW-1:0] m_dat_o,
   output logic          m_ack_o,
   // board pins
   input  logic          cgen_st_status_i,
   input  logic          cgen_st_ld_i,
   input  logic          cgen_st_refmon_i,
   input  logic          pps_i,
   output logic [1:0]    leds_o,
   output logic          cgen_sync_b_o,
   output logic          cgen_ref_sel_o
);

   wb_if misc_bus ();
   wb_if rdbk_bus ();
   wb_if set_bus ();

   logic              set_stb;
   logic [SET_AW-1:0] set_addr;
   logic [SET_DW-1:0] set_data;

   logic [63:0]       vita_time;
   logic [63:0]       vita_time_pps;
   logic [31:0]       reg_test32;

   ////////////////////
   // interconnect

   wb_intercon intercon_i (
      .wb_clk   (wb_clk),
      .wb_rst   (wb_rst),
      .m_adr_i  (m_adr_i),
      .m_dat_i  (m_dat_i),
      .m_sel_i  (m_sel_i),
      .m_we_i   (m_we_i),
      .m_cyc_i  (m_cyc_i),
      .m_stb_i  (m_stb_i),
      .m_dat_o  (m_dat_o),
      .m_ack_o  (m_ack_o),
      .misc     (misc_bus.master),
      .rdbk     (rdbk_bus.master),
      .settings (set_bus.master)
   );

   ////////////////////
   // slave 0, leds and clock gen

   misc_regs misc_regs_i (
      .wb_clk           (wb_clk),
      .wb_rst           (wb_rst),
      .bus              (misc_bus.slave),
      .cgen_st_status_i (cgen_st_status_i),
      .cgen_st_ld_i     (cgen_st_ld_i),
      .cgen_st_refmon_i (cgen_st_refmon_i),
      .leds_o           (leds_o),
      .cgen_sync_b_o    (cgen_sync_b_o),
      .cgen_ref_sel_o   (cgen_ref_sel_o)
   );

   ////////////////////
   // settings bus, slaves 8 and 9

   settings_bus_16le #(.rwidth(6)) settings_bus_i (  // 64 regs of 32 bits
      .wb_clk     (wb_clk),
      .wb_rst     (wb_rst),
      .bus        (set_bus.slave),
      .set_stb_o  (set_stb),
      .set_addr_o (set_addr),
      .set_data_o (set_data)
   );

   setting_reg #(.my_addr(SR_REG_TEST32), .width(32)) sr_reg_test32 (
      .wb_clk     (wb_clk),
      .wb_rst     (wb_rst),
      .set_stb_i  (set_stb),
      .set_addr_i (set_addr),
      .set_data_i (set_data),
      .out_o      (reg_test32),
      .changed_o  ()
   );

   time_64bit #(.base(SR_TIME64)) time_64bit_i (
      .wb_clk          (wb_clk),
      .wb_rst          (wb_rst),
      .set_stb_i       (set_stb),
      .set_addr_i      (set_addr),
      .set_data_i      (set_data),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps)
   );

   ////////////////////
   // slave 7, 32 bit readback

   wb_readback_mux_16le readback_i (
      .wb_clk          (wb_clk),
      .wb_rst          (wb_rst),
      .bus             (rdbk_bus.slave),
      .vita_time_i     (vita_time),
      .vita_time_pps_i (vita_time_pps),
      .test32_i        (reg_test32)
   );

endmodule

// ==== testbench/u1e_core_sva.sv ====
module u1e_core_sva (
   input logic wb_clk,
   input logic wb_rst,
   input logic m_cyc_i,
   input logic m_stb_i,
   input logic m_ack_i,
   input logic cgen_sync_b_i,
   input logic cgen_ref_sel_i,
   input logic rdbk_ack_i,
   input logic set_stb_i
);
   timeunit 1ns;
   timeprecision 1ps;

   ////////////////////
   // host handshake

   ack_in_cycle : assert property (@(posedge wb_clk) disable iff (wb_rst)
      m_ack_i |-> (m_cyc_i && m_stb_i))
      else $error("ack without cyc and stb");

   rdbk_ack_single : assert property (@(posedge wb_clk) disable iff (wb_rst)
      rdbk_ack_i |=> !rdbk_ack_i)
      else $error("readback ack high two cycles in a row");

   set_stb_single : assert property (@(posedge wb_clk) disable iff (wb_rst)
      set_stb_i |=> !set_stb_i)
      else $error("settings strobe high two cycles in a row");

   // first cycle out of reset
   reset_state : assert property (@(posedge wb_clk)
      $fell(wb_rst) |-> (!m_ack_i && cgen_sync_b_i && cgen_ref_sel_i))
      else $error("outputs not at reset values after reset");

endmodule

bind u1e_core u1e_core_sva sva_i (
   .wb_clk         (wb_clk),
   .wb_rst         (wb_rst),
   .m_cyc_i        (m_cyc_i),
   .m_stb_i        (m_stb_i),
   .m_ack_i        (m_ack_o),
   .cgen_sync_b_i  (cgen_sync_b_o),
   .cgen_ref_sel_i (cgen_ref_sel_o),
   .rdbk_ack_i     (rdbk_bus.ack),
   .set_stb_i      (set_stb)
);

// ==== testbench/tb_u1e_core.sv ====
module tb_u1e_core;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int MAX_CYCLES = 4000;   // several times the longest run

   // host addresses, slave in adr[10:7]
   localparam logic [10:0] ADR_LEDS      = 11'h000;
   localparam logic [10:0] ADR_CGEN_CTRL = 11'h004;
   localparam logic [10:0] ADR_CGEN_ST   = 11'h006;
   localparam logic [10:0] ADR_TEST      = 11'h008;
   localparam logic [10:0] ADR_COMPAT    = 11'h010;
   localparam logic [10:0] ADR_UNKNOWN   = 11'h022;  // unused slave 0 offset
   localparam logic [10:0] ADR_SLAVE5    = 11'h280;

   logic        wb_clk = 1'b0;
   logic        wb_rst;
   logic [10:0] m_adr;
   logic [15:0] m_dat_wr;
   logic [1:0]  m_sel;
   logic        m_we, m_cyc, m_stb;
   logic [15:0] m_dat_rd;
   logic        m_ack;
   logic        cgen_st_status, cgen_st_ld, cgen_st_refmon, pps;
   logic [1:0]  leds;
   logic        cgen_sync_b, cgen_ref_sel;

   // write shadows for the reference model
   logic [15:0] sh_leds, sh_test;
   logic [1:0]  sh_cgen;
   logic [31:0] sh_test32;

   int          cycles = 0;
   int          checks = 0;
   int          mismatches = 0;
   int          others = 0;
   logic [31:0] load_hi, load_lo, lo_word;
   logic [63:0] t_now, t_a, t_b, t_pps;
   int          c0, c1;

   u1e_core dut_i (
      .wb_clk           (wb_clk),
      .wb_rst           (wb_rst),
      .m_adr_i          (m_adr),
      .m_dat_i          (m_dat_wr),
      .m_sel_i          (m_sel),
      .m_we_i           (m_we),
      .m_cyc_i          (m_cyc),
      .m_stb_i          (m_stb),
      .m_dat_o          (m_dat_rd),
      .m_ack_o          (m_ack),
      .cgen_st_status_i (cgen_st_status),
      .cgen_st_ld_i     (cgen_st_ld),
      .cgen_st_refmon_i (cgen_st_refmon),
      .pps_i            (pps),
      .leds_o           (leds),
      .cgen_sync_b_o    (cgen_sync_b),
      .cgen_ref_sel_o   (cgen_ref_sel)
   );

   always #20 wb_clk = ~wb_clk;

   always @(posedge wb_clk)
   begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Timeout: test did not finish within %0d cycles", MAX_CYCLES);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   ////////////////////
   // reference model

   function automatic logic [10:0] rdbk_adr(input int word, input bit upper);
      return 11'h380 | 11'(word << 2) | {upper, 1'b0};
   endfunction

   function automatic logic [10:0] set_adr(input int sr, input bit upper);
      return 11'h400 | 11'(sr << 2) | {upper, 1'b0};
   endfunction

   function automatic logic [15:0] ref_read(input logic [10:0] addr);
      logic [15:0] res;
      res = 16'h0000;                     // unmapped and write only slaves
      if (addr[10:7] == 4'd0)
      begin
         case (addr[6:0])
            7'd0    : res = sh_leds;
            7'd4    : res = {14'd0, sh_cgen};
            7'd6    : res = {13'd0, cgen_st_status, cgen_st_ld, cgen_st_refmon};
            7'd8    : res = sh_test;
            7'd16   : res = 16'd3;        // compat number
            default : res = 16'hBEEF;
         endcase
      end
      else if (addr[10:7] == 4'd7 && addr[5:2] == 4'd4)
         res = addr[1] ? sh_test32[31:16] : sh_test32[15:0];
      return res;
   endfunction

   ////////////////////
   // bus tasks

   task automatic wait_ack();
      @(negedge wb_clk);
      while (!m_ack)
         @(negedge wb_clk);
   endtask

   task automatic bus_write(input logic [10:0] addr, input logic [15:0] data);
      @(posedge wb_clk);
      #2;
      m_adr    = addr;
      m_dat_wr = data;
      m_sel    = 2'b11;
      m_we     = 1'b1;
      m_cyc    = 1'b1;
      m_stb    = 1'b1;
      wait_ack();
      @(posedge wb_clk);
      #2;
      m_we  = 1'b0;
      m_cyc = 1'b0;
      m_stb = 1'b0;
   endtask

   task automatic bus_read(input logic [10:0] addr, output logic [15:0] data);
      @(posedge wb_clk);
      #2;
      m_adr = addr;
      m_sel = 2'b11;
      m_we  = 1'b0;
      m_cyc = 1'b1;
      m_stb = 1'b1;
      wait_ack();
      data = m_dat_rd;                    // stable at the falling edge
      @(posedge wb_clk);
      #2;
      m_cyc = 1'b0;
      m_stb = 1'b0;
   endtask

   task automatic write_setting(input int sr, input logic [31:0] value);
      bus_write(set_adr(sr, 1'b0), value[15:0]);
      bus_write(set_adr(sr, 1'b1), value[31:16]);   // strobe goes out here
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
      checks++;
      if (got !== exp)
      begin
         mismatches++;
         $display("Mismatch at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
      end
   endtask

   task automatic check_read(input logic [10:0] addr, input string name);
      logic [15:0] got;
      bus_read(addr, got);
      check_value(name, ref_read(addr), got);
   endtask

   task automatic read_time(input int word_hi, output logic [63:0] t);
      bus_read(rdbk_adr(word_hi, 1'b1), t[63:48]);
      bus_read(rdbk_adr(word_hi, 1'b0), t[47:32]);
      bus_read(rdbk_adr(word_hi + 1, 1'b1), t[31:16]);
      bus_read(rdbk_adr(word_hi + 1, 1'b0), t[15:0]);
   endtask

   ////////////////////
   // test sequence

   initial
   begin
      void'($urandom(7));
      wb_rst = 1'b1;
      {m_adr, m_dat_wr, m_sel, m_we, m_cyc, m_stb} = '0;
      {cgen_st_status, cgen_st_ld, cgen_st_refmon, pps} = '0;
      sh_leds   = '0;
      sh_test   = '0;
      sh_cgen   = 2'b11;
      sh_test32 = '0;
      repeat (5) @(posedge wb_clk);
      #2 wb_rst = 1'b0;

      // reset values
      check_value("leds_o", 32'd0, leds);
      check_value("cgen_sync_b_o", 32'd1, cgen_sync_b);
      check_value("cgen_ref_sel_o", 32'd1, cgen_ref_sel);
      check_read(ADR_COMPAT, "compat");
      check_read(ADR_CGEN_CTRL, "cgen_ctrl");
      check_read(ADR_UNKNOWN, "unknown offset");

      // slave 0 registers and pins
      repeat (4)
      begin
         sh_leds = $urandom;
         bus_write(ADR_LEDS, sh_leds);
         sh_test = $urandom;
         bus_write(ADR_TEST, sh_test);
         sh_cgen = $urandom;
         bus_write(ADR_CGEN_CTRL, {14'd0, sh_cgen});
         {cgen_st_status, cgen_st_ld, cgen_st_refmon} = $urandom;
         check_value("leds_o", sh_leds[1:0], leds);
         check_value("cgen_sync_b_o", sh_cgen[1], cgen_sync_b);
         check_value("cgen_ref_sel_o", sh_cgen[0], cgen_ref_sel);
         check_read(ADR_LEDS, "leds");
         check_read(ADR_TEST, "test");
         check_read(ADR_CGEN_CTRL, "cgen_ctrl");
         check_read(ADR_CGEN_ST, "cgen_st");
      end

      // settings bus into the test register
      repeat (4)
      begin
         sh_test32 = $urandom;
         write_setting(52, sh_test32);
         repeat (2) @(posedge wb_clk);    // strobe, then register update
         check_read(rdbk_adr(4, 1'b1), "test32 high");
         check_read(rdbk_adr(4, 1'b0), "test32 low");
      end
      check_read(rdbk_adr(5, 1'b0), "readback word 5");

      // time load, low word small so no carry during the test
      load_hi = $urandom;
      load_lo = $urandom % 512;
      write_setting(40, load_hi);
      write_setting(41, load_lo);
      c0 = cycles;
      read_time(0, t_now);
      c1 = cycles;
      check_value("vita_time high", load_hi, t_now[63:32]);
      lo_word = t_now[31:0];
      checks++;
      if (lo_word < load_lo || lo_word >= load_lo + 32'(c1 - c0))
      begin
         others++;
         $display("vita_time low word %0d is outside %0d to %0d after the load",
                  lo_word, load_lo, load_lo + 32'(c1 - c0) - 1);
      end

      // pps capture between two time reads
      read_time(0, t_a);
      @(posedge wb_clk);
      #2 pps = 1'b1;
      repeat (4) @(posedge wb_clk);
      #2 pps = 1'b0;
      read_time(0, t_b);
      read_time(2, t_pps);
      checks++;
      if (!(t_pps > t_a && t_pps < t_b))
      begin
         others++;
         $display("captured PPS time %0h does not lie between %0h and %0h", t_pps, t_a, t_b);
      end

      // unmapped slave answers with zero
      check_read(ADR_SLAVE5, "slave 5 data");

      $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, others);
      if (mismatches == 0 && others == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// ==== project.f ====
hw/u1e_pkg.sv
hw/wb_if.sv
hw/setting_reg.sv
hw/time_64bit.sv
hw/settings_bus_16le.sv
hw/misc_regs.sv
hw/wb_readback_mux_16le.sv
hw/wb_intercon.sv
hw/u1e_core.sv
testbench/u1e_core_sva.sv
testbench/tb_u1e_core.sv

// ==== Bender.yml ====
package:
  name: u1e_core

sources:
  - hw/u1e_pkg.sv
  - hw/wb_if.sv
  - hw/setting_reg.sv
  - hw/time_64bit.sv
  - hw/settings_bus_16le.sv
  - hw/misc_regs.sv
  - hw/wb_readback_mux_16le.sv
  - hw/wb_intercon.sv
  - hw/u1e_core.sv
  - target: test
    files:
      - testbench/u1e_core_sva.sv
      - testbench/tb_u1e_core.sv
